/* Makefile */
# Verilator build and run of the key-value store testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = kvs_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* kvs_addr_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kvs_consts.svh"

module kvs_addr_alloc (
    input  wire                          clk,
    input  wire                          rst_n,
    // lowest free address, claimed by a take pulse
    output logic                         alloc_valid,
    output kvs_store_pkg::kvs_addr_t     alloc_addr,
    input  wire                          alloc_take,
    // address coming back from a delete
    input  wire                          free_valid,
    input  wire kvs_store_pkg::kvs_addr_t free_addr
);

    import kvs_store_pkg::*;

    // one bit per value address, set = free
    logic [`KVS_VALUES-1:0] free_map;

    assign alloc_valid = |free_map;

    // priority encoder
    // walk down so the lowest set bit wins
    always_comb begin
        alloc_addr = '0;
        for (int i = `KVS_VALUES - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_addr = kvs_addr_t'(i);
            end
        end
    end

    // take and release may land in the same cycle
    // they never name the same address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_map <= '1;
        end else begin
            if (alloc_take) begin
                free_map[alloc_addr] <= 1'b0;
            end
            if (free_valid) begin
                free_map[free_addr] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* kvs_consts.svh */
`ifndef KVS_CONSTS_SVH
`define KVS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// word layout
////////////////////////////////////////////////////////////////////////////

// request and response words on the external streams
`define KVS_WORD_W    32
`define KVS_OP_W      2
`define KVS_KEY_W     8
// tag or value in a request, echo or value in a response
`define KVS_FIELD_W   16
`define KVS_STATUS_W  2

////////////////////////////////////////////////////////////////////////////
// storage sizes and codes
////////////////////////////////////////////////////////////////////////////

`define KVS_SLOTS     16
`define KVS_VALUES    8

// opcode 3 is treated as a get
`define KVS_OP_GET    2'd0
`define KVS_OP_SET    2'd1
`define KVS_OP_DEL    2'd2

`define KVS_ST_OK       2'd0
`define KVS_ST_MISS     2'd1
`define KVS_ST_COLLIDE  2'd2
`define KVS_ST_NOMEM    2'd3

`endif

/* kvs_hash_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kvs_consts.svh"

module kvs_hash_table (
    input  wire                            clk,
    input  wire                            rst_n,
    // request stream
    input  wire                            in_valid,
    output logic                           in_ready,
    input  wire kvs_stream_pkg::kvs_req_u  in_data,
    // lookup result stream
    output logic                           lkp_valid,
    input  wire                            lkp_ready,
    output kvs_stream_pkg::kvs_req_u       lkp_req,
    output logic                           lkp_hit,
    output logic                           lkp_free,
    output kvs_store_pkg::kvs_addr_t       lkp_addr,
    // completion from the value path
    input  wire                            upd_valid,
    input  wire                            upd_write,
    input  wire kvs_store_pkg::kvs_entry_t upd_entry
);

    import kvs_store_pkg::*;

    // slot = upper nibble xor lower nibble
    function automatic kvs_slot_t slot_of(input logic [`KVS_KEY_W-1:0] key);
        return key[`KVS_KEY_W-1:`KVS_KEY_W/2] ^ key[`KVS_KEY_W/2-1:0];
    endfunction

    // table storage
    logic [`KVS_SLOTS-1:0]  slot_valid;
    logic [`KVS_KEY_W-1:0]  slot_key [`KVS_SLOTS];
    kvs_addr_t              slot_addr [`KVS_SLOTS];

    // request in flight
    logic                   pending;
    kvs_slot_t              in_slot;
    kvs_slot_t              slot_q;
    kvs_entry_t             entry_q;

    assign in_slot  = slot_of(in_data.key_view.key);
    // one request at a time
    assign in_ready = !pending;

    ////////////////////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            lkp_valid  <= 1'b0;
            slot_valid <= '0;
        end else begin
            if (in_valid && in_ready) begin
                pending   <= 1'b1;
                lkp_valid <= 1'b1;
            end else if (lkp_valid && lkp_ready) begin
                lkp_valid <= 1'b0;
            end
            // completion frees the table for the next request
            if (upd_valid) begin
                pending <= 1'b0;
            end
            // entry with valid clear means delete
            if (upd_valid && upd_write) begin
                slot_valid[slot_q] <= upd_entry.valid;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry read and write
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // registered read of the hashed slot
        if (in_valid && in_ready) begin
            lkp_req       <= in_data;
            slot_q        <= in_slot;
            entry_q.valid <= slot_valid[in_slot];
            entry_q.key   <= slot_key[in_slot];
            entry_q.addr  <= slot_addr[in_slot];
        end
        if (upd_valid && upd_write) begin
            slot_key[slot_q]  <= upd_entry.key;
            slot_addr[slot_q] <= upd_entry.addr;
        end
    end

    // hit needs the full key, a neighbour in the slot is not enough
    assign lkp_hit  = entry_q.valid && (entry_q.key == lkp_req.key_view.key);
    assign lkp_free = !entry_q.valid;
    assign lkp_addr = entry_q.addr;

endmodule

`default_nettype wire

/* kvs_input.txt */
# columns: op key field expected_status expected_field, all hex
# op 0 get, 1 set, 2 delete, 3 get; status 0 ok, 1 miss, 2 collide, 3 nomem
0 10 aaaa 1 aaaa
2 10 bbbb 1 bbbb
1 10 1111 0 1111
0 10 0001 0 1111
1 20 2222 0 2222
1 30 3333 0 3333
1 40 4444 0 4444
1 50 5555 0 5555
1 60 6666 0 6666
1 70 7777 0 7777
1 80 8888 0 8888
1 90 9999 3 9999
1 30 3a3a 0 3a3a
0 30 0002 0 3a3a
1 01 dead 2 dead
0 10 0003 0 1111
0 01 0004 1 0004
2 50 0005 0 0005
1 90 9999 0 9999
0 50 0006 1 0006
0 90 0007 0 9999
0 20 0008 0 2222
0 40 0009 0 4444
0 60 000a 0 6666
3 80 000b 0 8888
2 90 000c 0 000c
2 90 000d 1 000d
0 90 000e 1 000e
1 50 5a5a 0 5a5a
0 50 000f 0 5a5a
2 10 0010 0 0010
1 01 0101 0 0101
0 01 0011 0 0101
0 10 0012 1 0012
1 11 1212 3 1212
0 70 0013 0 7777
0 30 0014 0 3a3a

/* kvs_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module kvs_properties (
    input wire                            clk,
    input wire                            rst_n,
    input wire                            in_ready,
    input wire                            lkp_valid,
    input wire                            alloc_valid,
    input wire                            alloc_take,
    input wire                            out_valid,
    input wire                            out_ready,
    input wire kvs_stream_pkg::kvs_resp_t out_data
);

    ////////////////////////////////////////////////////////////////////////////
    // response stream
    ////////////////////////////////////////////////////////////////////////////

    // response held until taken
    property p_out_hold;
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    a_out_hold: assert property (p_out_hold)
        else $error("response dropped or changed before out_ready");

    ////////////////////////////////////////////////////////////////////////////
    // internal handshakes
    ////////////////////////////////////////////////////////////////////////////

    // one request in the table at a time
    property p_single_request;
        @(posedge clk) disable iff (!rst_n)
        lkp_valid |-> !in_ready;
    endproperty

    a_single_request: assert property (p_single_request)
        else $error("table accepting a request while a lookup is outstanding");

    // only claim an address that exists
    property p_take_needs_free;
        @(posedge clk) disable iff (!rst_n)
        alloc_take |-> alloc_valid;
    endproperty

    a_take_needs_free: assert property (p_take_needs_free)
        else $error("address claimed with no free address left");

endmodule

bind kvs_top kvs_properties u_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_ready    (in_ready),
    .lkp_valid   (lkp_valid),
    .alloc_valid (alloc_valid),
    .alloc_take  (alloc_take),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data)
);

`default_nettype wire

/* kvs_store_pkg.sv */
`default_nettype none

`include "kvs_consts.svh"

package kvs_store_pkg;

    // value memory address, one per storable key
    typedef logic [$clog2(`KVS_VALUES)-1:0] kvs_addr_t;

    // hash table slot index
    typedef logic [$clog2(`KVS_SLOTS)-1:0] kvs_slot_t;

    // one table entry
    // valid bit, full key for the compare, and where the value lives
    typedef struct packed {
        logic                  valid;
        logic [`KVS_KEY_W-1:0] key;
        kvs_addr_t             addr;
    } kvs_entry_t;

endpackage

`default_nettype wire

/* kvs_stream_pkg.sv */
`default_nettype none

`include "kvs_consts.svh"

package kvs_stream_pkg;

    // get and delete view
    // low field is a tag that comes back in the response
    typedef struct packed {
        logic [`KVS_WORD_W-`KVS_OP_W-`KVS_KEY_W-`KVS_FIELD_W-1:0] rsvd;
        logic [`KVS_OP_W-1:0]    op;
        logic [`KVS_KEY_W-1:0]   key;
        logic [`KVS_FIELD_W-1:0] tag;
    } kvs_key_view_t;

    // set view
    // low field is the value to store
    typedef struct packed {
        logic [`KVS_WORD_W-`KVS_OP_W-`KVS_KEY_W-`KVS_FIELD_W-1:0] rsvd;
        logic [`KVS_OP_W-1:0]    op;
        logic [`KVS_KEY_W-1:0]   key;
        logic [`KVS_FIELD_W-1:0] value;
    } kvs_store_view_t;

    // one request word, two readings of the low field
    typedef union packed {
        kvs_key_view_t   key_view;
        kvs_store_view_t store_view;
    } kvs_req_u;

    // response word, status sits where the request opcode was
    typedef struct packed {
        logic [`KVS_WORD_W-`KVS_STATUS_W-`KVS_KEY_W-`KVS_FIELD_W-1:0] rsvd;
        logic [`KVS_STATUS_W-1:0] status;
        logic [`KVS_KEY_W-1:0]    key;
        logic [`KVS_FIELD_W-1:0]  field;
    } kvs_resp_t;

endpackage

`default_nettype wire

/* kvs_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kvs_consts.svh"

module kvs_tb;

    import kvs_stream_pkg::*;

    localparam int LINE_CHARS = 128;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    kvs_req_u  in_data;
    logic      out_valid;
    logic      out_ready;
    kvs_resp_t out_data;

    // vectors with one entry per file line
    logic [`KVS_OP_W-1:0]     vec_op [$];
    logic [`KVS_KEY_W-1:0]    vec_key [$];
    logic [`KVS_FIELD_W-1:0]  vec_field [$];
    logic [`KVS_STATUS_W-1:0] vec_status [$];
    logic [`KVS_FIELD_W-1:0]  vec_expect [$];

    // tests accepted by the DUT in arrival order
    int pend_test [$];

    integer seed = 32'hf79d_edd5;
    int     n_vec = 0;
    int     sent = 0;
    int     received = 0;
    int     passed = 0;
    int     errors = 0;
    int     cycle_count = 0;
    int     limit_cycles = 0;
    bit     load_ok;

    kvs_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    // limit is set once the vectors are known
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (limit_cycles > 0 && cycle_count > limit_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     limit_cycles, received, n_vec);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // vector file
    ////////////////////////////////////////////////////////////////////////////

    // lines that do not hold five hex numbers are skipped
    task automatic read_vectors(output bit ok);
        int                      fd;
        int                      n;
        logic [8*LINE_CHARS-1:0] line;
        logic [31:0]             t_op;
        logic [31:0]             t_key;
        logic [31:0]             t_field;
        logic [31:0]             t_st;
        logic [31:0]             t_exp;
        ok = 1'b0;
        fd = $fopen("kvs_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h", t_op, t_key, t_field, t_st, t_exp);
                    if (n == 5) begin
                        vec_op.push_back(t_op[`KVS_OP_W-1:0]);
                        vec_key.push_back(t_key[`KVS_KEY_W-1:0]);
                        vec_field.push_back(t_field[`KVS_FIELD_W-1:0]);
                        vec_status.push_back(t_st[`KVS_STATUS_W-1:0]);
                        vec_expect.push_back(t_exp[`KVS_FIELD_W-1:0]);
                    end
                end
            end
            $fclose(fd);
            ok = (vec_op.size() > 0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and response check
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_request(input int idx);
        in_data                = '0;
        in_data.key_view.op    = vec_op[idx];
        in_data.key_view.key   = vec_key[idx];
        in_data.key_view.tag   = vec_field[idx];
        in_valid               = 1'b1;
    endtask

    // response key is always the request key
    task automatic check_response;
        kvs_resp_t expect_word;
        int        idx;
        if (pend_test.size() == 0) begin
            $display("response %h at %0t arrived with no request outstanding",
                     out_data, $time);
            errors++;
        end else begin
            idx                = pend_test.pop_front();
            expect_word        = '0;
            expect_word.status = vec_status[idx];
            expect_word.key    = vec_key[idx];
            expect_word.field  = vec_expect[idx];
            received++;
            if (out_data !== expect_word) begin
                $display("MISMATCH at %0t: test %0d op %0d key %h got %h expected %h",
                         $time, idx, vec_op[idx], vec_key[idx], out_data, expect_word);
                errors++;
                $display("test %2d op %0d key %h: failed", idx, vec_op[idx], vec_key[idx]);
            end else begin
                passed++;
                $display("test %2d op %0d key %h: status %0d field %h ok",
                         idx, vec_op[idx], vec_key[idx], out_data.status, out_data.field);
            end
        end
    endtask

    // drive at edge plus 1 ns and sample at edge minus 1 ns
    task automatic run_traffic;
        bit in_hs;
        bit out_hs;
        int in_table;
        while (received < n_vec) begin
            out_ready = (($random(seed) & 3) != 0);
            // occasional idle cycle between requests
            if (!in_valid && sent < n_vec && (($random(seed) & 7) != 0)) begin
                drive_request(sent);
            end
            #6;
            // a request leaves the table when its response is loaded
            in_table = sent - received - (out_valid ? 1 : 0);
            if (in_ready !== (in_table == 0)) begin
                $display("MISMATCH at %0t: in_ready %b with %0d requests in the table",
                         $time, in_ready, in_table);
                errors++;
            end
            in_hs  = in_valid && in_ready;
            out_hs = out_valid && out_ready;
            if (in_hs) begin
                pend_test.push_back(sent);
                sent++;
            end
            if (out_hs) begin
                check_response();
            end
            @(posedge clk);
            #1;
            if (in_hs) begin
                in_valid = 1'b0;
            end
        end
    endtask

    // nothing more may come out
    task automatic check_idle;
        out_ready = 1'b1;
        repeat (6) begin
            #6;
            if (out_valid) begin
                $display("extra response %h at %0t after all %0d requests were answered",
                         out_data, $time, n_vec);
                errors++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        read_vectors(load_ok);
        if (!load_ok) begin
            $display("stimulus file kvs_input.txt is missing or holds no vectors");
            $display("ERRORS FOUND");
        end else begin
            n_vec        = vec_op.size();
            limit_cycles = n_vec * 20 + 100;
            repeat (5) @(posedge clk);
            #1;
            rst_n = 1'b1;
            run_traffic();
            check_idle();
            $display("%0d tests, %0d passed, %0d failed, %0d errors in total",
                     n_vec, passed, n_vec - passed, errors);
            if (errors == 0 && passed == n_vec) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* kvs_top.sv */
`timescale 1ns/1ps
`default_nettype none

module kvs_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           in_valid,
    output logic                          in_ready,
    input  wire kvs_stream_pkg::kvs_req_u in_data,
    output logic                          out_valid,
    input  wire                           out_ready,
    output kvs_stream_pkg::kvs_resp_t     out_data
);

    import kvs_stream_pkg::*;
    import kvs_store_pkg::*;

    // table to value path
    logic       lkp_valid;
    logic       lkp_ready;
    kvs_req_u   lkp_req;
    logic       lkp_hit;
    logic       lkp_free;
    kvs_addr_t  lkp_addr;

    // allocator handshake
    logic       alloc_valid;
    kvs_addr_t  alloc_addr;
    logic       alloc_take;
    logic       free_valid;
    kvs_addr_t  free_addr;

    // completion to the table
    logic       upd_valid;
    logic       upd_write;
    kvs_entry_t upd_entry;

    ////////////////////////////////////////////////////////////////////////////
    // lookup, allocation and value path side by side
    ////////////////////////////////////////////////////////////////////////////

    kvs_hash_table u_hash_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .lkp_valid (lkp_valid),
        .lkp_ready (lkp_ready),
        .lkp_req   (lkp_req),
        .lkp_hit   (lkp_hit),
        .lkp_free  (lkp_free),
        .lkp_addr  (lkp_addr),
        .upd_valid (upd_valid),
        .upd_write (upd_write),
        .upd_entry (upd_entry)
    );

    kvs_addr_alloc u_addr_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_valid (alloc_valid),
        .alloc_addr  (alloc_addr),
        .alloc_take  (alloc_take),
        .free_valid  (free_valid),
        .free_addr   (free_addr)
    );

    kvs_value_path u_value_path (
        .clk         (clk),
        .rst_n       (rst_n),
        .lkp_valid   (lkp_valid),
        .lkp_ready   (lkp_ready),
        .lkp_req     (lkp_req),
        .lkp_hit     (lkp_hit),
        .lkp_free    (lkp_free),
        .lkp_addr    (lkp_addr),
        .alloc_valid (alloc_valid),
        .alloc_addr  (alloc_addr),
        .alloc_take  (alloc_take),
        .free_valid  (free_valid),
        .free_addr   (free_addr),
        .upd_valid   (upd_valid),
        .upd_write   (upd_write),
        .upd_entry   (upd_entry),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

/* kvs_value_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kvs_consts.svh"

module kvs_value_path (
    input  wire                            clk,
    input  wire                            rst_n,
    // lookup result from the table
    input  wire                            lkp_valid,
    output logic                           lkp_ready,
    input  wire kvs_stream_pkg::kvs_req_u  lkp_req,
    input  wire                            lkp_hit,
    input  wire                            lkp_free,
    input  wire kvs_store_pkg::kvs_addr_t  lkp_addr,
    // allocator
    input  wire                            alloc_valid,
    input  wire kvs_store_pkg::kvs_addr_t  alloc_addr,
    output logic                           alloc_take,
    output logic                           free_valid,
    output kvs_store_pkg::kvs_addr_t       free_addr,
    // completion back to the table
    output logic                           upd_valid,
    output logic                           upd_write,
    output kvs_store_pkg::kvs_entry_t      upd_entry,
    // response stream
    output logic                           out_valid,
    input  wire                            out_ready,
    output kvs_stream_pkg::kvs_resp_t      out_data
);

    import kvs_stream_pkg::*;
    import kvs_store_pkg::*;

    // value store
    logic [`KVS_FIELD_W-1:0]  value_mem [`KVS_VALUES];

    // stage between lookup and response
    logic                     s1_valid;
    kvs_req_u                 s1_req;
    logic                     s1_hit;
    logic                     s1_free;
    kvs_addr_t                s1_addr;

    // decoded action
    logic [`KVS_OP_W-1:0]     op;
    logic                     op_set;
    logic                     op_del;
    logic [`KVS_STATUS_W-1:0] status;
    logic [`KVS_FIELD_W-1:0]  resp_field;
    logic                     mem_we;
    kvs_addr_t                mem_addr;

    // response slot is empty now, or empties on this edge
    assign lkp_ready = !out_valid || out_ready;

    ////////////////////////////////////////////////////////////////////////////
    // action select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        op         = s1_req.key_view.op;
        op_set     = (op == `KVS_OP_SET);
        op_del     = (op == `KVS_OP_DEL);
        status     = `KVS_ST_OK;
        resp_field = s1_req.key_view.tag;
        mem_we     = 1'b0;
        mem_addr   = s1_addr;
        alloc_take = 1'b0;
        free_valid = 1'b0;
        upd_write  = 1'b0;
        if (op_set) begin
            if (s1_hit) begin
                // overwrite in place with the entry unchanged
                mem_we = 1'b1;
            end else if (s1_free && alloc_valid) begin
                mem_we     = 1'b1;
                mem_addr   = alloc_addr;
                alloc_take = s1_valid;
                upd_write  = 1'b1;
            end else if (s1_free) begin
                status = `KVS_ST_NOMEM;
            end else begin
                // slot taken by another key so no eviction
                status = `KVS_ST_COLLIDE;
            end
        end else if (op_del) begin
            if (s1_hit) begin
                free_valid = s1_valid;
                upd_write  = 1'b1;
            end else begin
                status = `KVS_ST_MISS;
            end
        end else if (s1_hit) begin
            resp_field = value_mem[s1_addr];
        end else begin
            status = `KVS_ST_MISS;
        end
        // valid clear on a delete invalidates the slot
        upd_entry.valid = op_set;
        upd_entry.key   = s1_req.key_view.key;
        upd_entry.addr  = mem_addr;
    end

    assign upd_valid = s1_valid;
    assign free_addr = s1_addr;

    ////////////////////////////////////////////////////////////////////////////
    // stage, memory and response registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid <= lkp_valid && lkp_ready;
            // stage always finds the response slot free
            if (s1_valid) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lkp_valid && lkp_ready) begin
            s1_req  <= lkp_req;
            s1_hit  <= lkp_hit;
            s1_free <= lkp_free;
            s1_addr <= lkp_addr;
        end
        if (s1_valid && mem_we) begin
            value_mem[mem_addr] <= s1_req.store_view.value;
        end
        if (s1_valid) begin
            out_data.rsvd   <= '0;
            out_data.status <= status;
            out_data.key    <= s1_req.key_view.key;
            out_data.field  <= resp_field;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
kvs_stream_pkg.sv
kvs_store_pkg.sv
kvs_hash_table.sv
kvs_addr_alloc.sv
kvs_value_path.sv
kvs_top.sv
kvs_properties.sv
kvs_tb.sv
